// File: sources.f
fmaPkg.sv
specialCases.sv
boothMultiplier.sv
addendAlign.sv
significandAdder.sv
normalizer.sv
rounder.sv
fmaUnit.sv
clockGen.sv
fmaUnit_props.sv
tb_fmaUnit.sv

// File: Makefile
# Verilator build and run of the FMA testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fmaUnit \
		-f sources.f -Mdir obj_dir
	./obj_dir/Vtb_fmaUnit 2>&1 | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: tb_fmaUnit.sv
`timescale 1ns/10ps

module tb_fmaUnit;

  logic              clk, rst, inValid, outValid;
  fmaPkg::bf16T      a, b;
  fmaPkg::fp32T      c, result;
  fmaPkg::roundModeE rnd;

  logic [15:0]       vecA[$], vecB[$];
  logic [31:0]       vecC[$];
  fmaPkg::roundModeE vecR[$];
  logic [31:0]       expQ[$];          // Expected words in issue order
  int                vecCount = 0;
  int                seenCount = 0;

  clockGen clk0 (.clk(clk), .rst(rst));

  fmaUnit dut0 (
    .clk(clk), .rst(rst), .inValid(inValid),
    .a(a), .b(b), .c(c), .rnd(rnd),
    .outValid(outValid), .result(result)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // A bfloat16 is the top half of an fp32, so one conversion serves both
  function automatic real fpToReal(fmaPkg::fp32T x);
    logic [10:0] e;
    e = {3'b000, x.exp} + 11'd896;     // Rebias 127 to 1023
    if (x.exp == '0) return 0.0;       // Subnormal reads as zero
    return $bitstoreal({x.sign, e, x.frac, 29'b0});
  endfunction

  function automatic logic [31:0] toFp32(real x, fmaPkg::roundModeE mode);
    logic [63:0] d;
    logic [10:0] e;
    logic [31:0] w;
    logic        inc;
    if (x == 0.0) return 32'h0;        // Exact cancellation is +0
    d   = $realtobits(x);
    e   = d[62:52] - 11'd896;
    w   = {d[63], e[7:0], d[51:29]};   // Truncated magnitude
    inc = (mode == fmaPkg::rndNearestEven) && d[28] && ((d[27:0] != '0) || w[0]);
    w[30:0] = w[30:0] + {30'b0, inc};  // Carry may bump the exponent
    return w;
  endfunction

  // Flag in bit 32 above the special word
  function automatic logic [32:0] specialRule(fmaPkg::bf16T x, fmaPkg::bf16T y,
                                              fmaPkg::fp32T z);
    logic xNaN, yNaN, zNaN, xInf, yInf, zInf, xZero, yZero, zZero, pSign;
    xNaN  = (x.exp == 8'hFF) && (x.frac != '0);
    yNaN  = (y.exp == 8'hFF) && (y.frac != '0);
    zNaN  = (z.exp == 8'hFF) && (z.frac != '0);
    xInf  = (x.exp == 8'hFF) && (x.frac == '0);
    yInf  = (y.exp == 8'hFF) && (y.frac == '0);
    zInf  = (z.exp == 8'hFF) && (z.frac == '0);
    xZero = (x.exp == 8'h00);
    yZero = (y.exp == 8'h00);
    zZero = (z.exp == 8'h00);
    pSign = x.sign ^ y.sign;
    if (xNaN || yNaN || zNaN || (xInf && yZero) || (yInf && xZero)) begin
      return {1'b1, 32'h7FC0_0000};
    end
    if ((xInf || yInf) && zInf && (pSign != z.sign)) return {1'b1, 32'h7FC0_0000};
    if (xInf || yInf) return {1'b1, pSign, 8'hFF, 23'h0};
    if (zInf) return {1'b1, z};
    if (xZero || yZero) return zZero ? {1'b1, pSign & z.sign, 31'h0} : {1'b1, z};
    return 33'h0;
  endfunction

  function automatic logic [31:0] expectedWord(fmaPkg::bf16T x, fmaPkg::bf16T y,
                                               fmaPkg::fp32T z, fmaPkg::roundModeE mode);
    logic [32:0] sp;
    sp = specialRule(x, y, z);
    if (sp[32]) return sp[31:0];
    // Exact in real for the exponent spans used below
    return toFp32(fpToReal({x, 16'h0}) * fpToReal({y, 16'h0}) + fpToReal(z), mode);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Vector list
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] randBf(int expLo, int expHi);
    logic [31:0] r;
    int          e;
    r = $urandom();
    e = expLo + int'(r[31:16]) % (expHi - expLo + 1);
    return {r[0], 8'(e), r[7:1]};
  endfunction

  task automatic addVector(logic [15:0] va, logic [15:0] vb, logic [31:0] vc,
                           fmaPkg::roundModeE vr);
    vecA.push_back(va);
    vecB.push_back(vb);
    vecC.push_back(vc);
    vecR.push_back(vr);
  endtask

  task automatic addBoth(logic [15:0] va, logic [15:0] vb, logic [31:0] vc);
    addVector(va, vb, vc, fmaPkg::rndNearestEven);
    addVector(va, vb, vc, fmaPkg::rndZero);
  endtask

  task automatic addRandom(logic effSubtract);
    logic [15:0] va, vb;
    logic [31:0] r;
    int          ce;
    va = randBf(100, 150);
    vb = randBf(100, 150);
    // Addend within 20 binades of the product
    ce = int'(va[14:7]) + int'(vb[14:7]) - 147 + int'($urandom() % 41);
    r  = $urandom();
    addBoth(va, vb, {va[15] ^ vb[15] ^ effSubtract, 8'(ce), r[22:0]});
  endtask

  // Addend is the negated product with low fraction bits flipped
  task automatic addCancel(logic [7:0] flip);
    logic [15:0] va, vb;
    logic [31:0] p;
    va = randBf(110, 140);
    vb = randBf(110, 140);
    p  = toFp32(fpToReal({va, 16'h0}) * fpToReal({vb, 16'h0}), fmaPkg::rndNearestEven);
    addBoth(va, vb, {~p[31], p[30:8], p[7:0] ^ flip});
  endtask

  task automatic buildVectors();
    repeat (24) addRandom(1'b0);
    repeat (20) addRandom(1'b1);
    addCancel(8'h00);                  // Exact zero
    repeat (5) addCancel(8'($urandom() % 255 + 1));
    addBoth(16'h3980, 16'h3980, 32'h3F80_0000);   // Tie that stays even
    addBoth(16'h3980, 16'h3980, 32'h3F80_0001);   // Tie that rounds up to even
    addBoth(16'h39C0, 16'h3980, 32'h3F80_0000);   // Above half
    addBoth(16'hB980, 16'h3980, 32'h3F80_0001);   // Tie after a subtract
    addVector(16'h7FC1, 16'h3F80, 32'h3F80_0000, fmaPkg::rndNearestEven);
    addVector(16'h3F80, 16'h4000, 32'h7FA0_0000, fmaPkg::rndZero);
    addVector(16'h7F80, 16'h0000, 32'h3F80_0000, fmaPkg::rndNearestEven);
    addVector(16'h7F80, 16'h3F80, 32'hFF80_0000, fmaPkg::rndNearestEven);
    addVector(16'hFF80, 16'h4000, 32'h3F80_0000, fmaPkg::rndZero);
    addVector(16'h4040, 16'hBF80, 32'h7F80_0000, fmaPkg::rndNearestEven);
    addVector(16'h0000, 16'h4040, 32'h4049_0FDB, fmaPkg::rndNearestEven);
    addVector(16'h0005, 16'h4040, 32'hC049_0FDB, fmaPkg::rndZero);  // Subnormal a
    addVector(16'h8000, 16'h3F80, 32'h8000_0000, fmaPkg::rndNearestEven);
    addVector(16'h0000, 16'hBF80, 32'h0000_0000, fmaPkg::rndNearestEven);
    addVector(16'h8000, 16'h3F80, 32'h0000_0000, fmaPkg::rndZero);
    addVector(16'h4040, 16'h4000, 32'h0000_0123, fmaPkg::rndNearestEven);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive, check, watchdog
  //////////////////////////////////////////////////////////////////////

  task automatic driveVector(int i);
    @(posedge clk);
    #1;
    inValid = 1'b1;
    a       = vecA[i];
    b       = vecB[i];
    c       = vecC[i];
    rnd     = vecR[i];
    expQ.push_back(expectedWord(vecA[i], vecB[i], vecC[i], vecR[i]));
  endtask

  task automatic driveIdle();
    @(posedge clk);
    #1;
    inValid = 1'b0;
  endtask

  initial begin
    void'($urandom(44));
    inValid = 1'b1;                    // Must be ignored while reset is high
    a       = '0;
    b       = '0;
    c       = '0;
    rnd     = fmaPkg::rndNearestEven;
    buildVectors();
    vecCount = vecA.size();
    @(negedge rst);
    inValid = 1'b0;
    for (int i = 0; i < vecCount; i++) begin
      if (i % 32 == 31) driveIdle();   // Gap in the stream
      driveVector(i);
    end
    driveIdle();
    while (expQ.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

  // Outputs are stable around the falling edge
  always @(negedge clk) begin : checkOutput
    logic [31:0] want;
    if (outValid === 1'b1) begin
      if (expQ.size() == 0) begin
        $display("Error: outValid went high with no operation in flight");
        $display("=== FAIL ===");
        $fatal(1);
      end else begin
        want = expQ.pop_front();
        seenCount++;
        assert (result === want) else begin
          $display("Error: result = 0x%08h, expected 0x%08h (output %0d)",
                   result, want, seenCount);
          $display("=== FAIL ===");
          $fatal(1);
        end
      end
    end
  end

  // Covers reset, gaps and the pipeline drain
  initial begin
    while (vecCount == 0) #1;
    #((vecCount + 20) * 40);
    $display("Error: outputs stopped arriving, %0d of %0d results seen",
             seenCount, vecCount);
    $display("=== FAIL ===");
    $fatal(1);
  end

endmodule

// File: fmaUnit_props.sv
`timescale 1ns/10ps

module fmaUnit_props (
  input logic         clk,
  input logic         rst,
  input logic         inValid,
  input logic         outValid,
  input fmaPkg::fp32T result
);

  //////////////////////////////////////////////////////////////////////
  // Pipeline timing
  //////////////////////////////////////////////////////////////////////

  // Quiet through reset and the two stages that drain behind it
  resetQuiet: assert property (@(posedge clk) (rst || $past(rst)) |=> !outValid)
    else $error("outValid high during reset or within two cycles after it");

  // Checked once both stages have refilled after reset
  latencyTwo: assert property (@(posedge clk) disable iff (rst)
                               !$past(rst) && !$past(rst, 2)
                               |-> outValid == $past(inValid, 2))
    else $error("outValid does not follow inValid by two cycles");

  resultKnown: assert property (@(posedge clk) outValid |-> !$isunknown(result))
    else $error("result has unknown bits while outValid is high");

endmodule

bind fmaUnit fmaUnit_props props0 (
  .clk(clk),
  .rst(rst),
  .inValid(inValid),
  .outValid(outValid),
  .result(result)
);

// File: clockGen.sv
`timescale 1ns/10ps

module clockGen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  // Reset held over the first five rising edges
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// File: fmaUnit.sv
`timescale 1ns/10ps

module fmaUnit (
  input  logic              clk,
  input  logic              rst,
  input  logic              inValid,
  input  fmaPkg::bf16T      a,
  input  fmaPkg::bf16T      b,
  input  fmaPkg::fp32T      c,
  input  fmaPkg::roundModeE rnd,
  output logic              outValid,
  output fmaPkg::fp32T      result
);

  fmaPkg::specialT special;
  fmaPkg::alignedT stage1, s1Data;
  fmaPkg::sumT     sum;
  fmaPkg::fp32T    rounded;
  logic [7:0]      aSig, bSig;
  logic [26:0]     normSig;
  logic [fmaPkg::expWidth-1:0] normExp;
  logic            normSign;
  logic            s1Valid;

  //////////////////////////////////////////////////////////////////////
  // Stage 1: classify, multiply, align
  //////////////////////////////////////////////////////////////////////

  // Hidden one, subnormal reads as zero
  assign aSig = (a.exp == '0) ? 8'd0 : {1'b1, a.frac};
  assign bSig = (b.exp == '0) ? 8'd0 : {1'b1, b.frac};

  specialCases sc0 (.a(a), .b(b), .c(c), .special(special));

  boothMultiplier mul0 (.mx(aSig), .my(bSig), .product(stage1.product));

  addendAlign aln0 (
    .a(a), .b(b), .c(c),
    .addendSig(stage1.addendSig),
    .sticky(stage1.sticky),
    .refExp(stage1.refExp),
    .effSub(stage1.effSub),
    .prodSign(stage1.prodSign)
  );

  assign stage1.rnd     = rnd;
  assign stage1.special = special;

  always_ff @(posedge clk) begin
    s1Data <= stage1;                 // Payload only
    if (rst) begin
      s1Valid <= 1'b0;
    end else begin
      s1Valid <= inValid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage 2: add, normalize, round, select
  //////////////////////////////////////////////////////////////////////

  significandAdder add0 (.stage(s1Data), .sum(sum));

  normalizer nrm0 (.sum(sum), .normSig(normSig), .normExp(normExp), .normSign(normSign));

  rounder rnd0 (
    .normSig(normSig), .normExp(normExp), .normSign(normSign),
    .rnd(s1Data.rnd), .rounded(rounded)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      result   <= '0;
    end else begin
      outValid <= s1Valid;
      result   <= s1Data.special.isSpecial ? s1Data.special.word : rounded;
    end
  end

endmodule

// File: rounder.sv
`timescale 1ns/10ps

module rounder (
  input  logic [26:0]                  normSig,
  input  logic [fmaPkg::expWidth-1:0]  normExp,
  input  logic                         normSign,
  input  fmaPkg::roundModeE            rnd,
  output fmaPkg::fp32T                 rounded
);

  logic [23:0]               sig;
  logic                      guardBit, roundBit, stickyBit;
  logic                      inc;
  logic [24:0]               sigInc;
  logic [23:0]               sigFinal;
  logic [fmaPkg::expWidth-1:0] expFinal;

  assign sig       = normSig[26:3];
  assign guardBit  = normSig[2];
  assign roundBit  = normSig[1];
  assign stickyBit = normSig[0];

  // Ties go to the even significand
  always_comb begin
    case (rnd)
      fmaPkg::rndNearestEven: inc = guardBit & (roundBit | stickyBit | sig[0]);
      default:                inc = 1'b0;   // Truncate
    endcase
  end

  assign sigInc = {1'b0, sig} + 25'(inc);

  // Carry out of the significand, shift back one place
  assign sigFinal = sigInc[24] ? sigInc[24:1] : sigInc[23:0];
  assign expFinal = sigInc[24] ? (normExp + 1'b1) : normExp;

  always_comb begin
    rounded.sign = normSign;
    rounded.exp  = expFinal;
    rounded.frac = sigFinal[22:0];   // Hidden one dropped
  end

endmodule

// File: normalizer.sv
`timescale 1ns/10ps

module normalizer (
  input  fmaPkg::sumT                  sum,
  output logic [26:0]                  normSig,
  output logic [fmaPkg::expWidth-1:0]  normExp,
  output logic                         normSign
);

  localparam int sw = fmaPkg::sumWidth;

  logic [5:0]                  lzc;
  logic [sw-1:0]               shifted;
  logic [fmaPkg::expWidth+1:0] expFull;
  logic                        isZero;

  // Exact leading-zero count, highest set bit wins
  always_comb begin
    lzc = '0;
    for (int i = 0; i < sw; i++) begin
      if (sum.mag[i]) begin
        lzc = 6'(sw - 1 - i);
      end
    end
  end

  assign isZero  = (sum.mag == '0);
  assign shifted = sum.mag << lzc;

  //////////////////////////////////////////////////////////////////////
  // 24 significand bits, guard, round, sticky
  //////////////////////////////////////////////////////////////////////

  assign normSig = {shifted[sw-1 -: 26], (|shifted[sw-27:0]) | sum.sticky};

  // Slot sw-2 carries refExp, leading one now at sw-1
  assign expFull  = sum.exp + (fmaPkg::expWidth + 2)'(1) - {4'b0000, lzc};
  assign normExp  = isZero ? '0 : expFull[fmaPkg::expWidth-1:0];
  assign normSign = sum.sign;

endmodule

// File: significandAdder.sv
`timescale 1ns/10ps

module significandAdder (
  input  fmaPkg::alignedT stage,
  output fmaPkg::sumT     sum
);

  localparam int sw = fmaPkg::sumWidth;

  logic [sw-1:0] prodWin;
  logic [sw+1:0] opA, opB, raw, magExt;
  logic          isNeg, isZero;

  // Product at its fixed place in the window
  assign prodWin = {{(sw - 16 - fmaPkg::prodLsb){1'b0}}, stage.product,
                    {fmaPkg::prodLsb{1'b0}}};

  // Extra LSB carries sticky so it borrows in a subtraction
  assign opA = {1'b0, prodWin, 1'b0};
  assign opB = {1'b0, stage.addendSig, stage.sticky};

  assign raw    = stage.effSub ? (opA - opB) : (opA + opB);
  assign isNeg  = stage.effSub & raw[sw+1];  // Addend was the larger term
  assign magExt = isNeg ? (~raw + 1'b1) : raw;
  assign isZero = (magExt == '0);

  always_comb begin
    sum.mag    = magExt[sw:1];
    sum.sticky = magExt[0];
    sum.exp    = stage.refExp;
    sum.sign   = isZero ? 1'b0 : (stage.prodSign ^ isNeg); // Exact zero is +0
  end

endmodule

// File: addendAlign.sv
`timescale 1ns/10ps

module addendAlign (
  input  fmaPkg::bf16T                 a,
  input  fmaPkg::bf16T                 b,
  input  fmaPkg::fp32T                 c,
  output logic [fmaPkg::sumWidth-1:0]  addendSig,
  output logic                         sticky,
  output logic [fmaPkg::expWidth+1:0]  refExp,
  output logic                         effSub,
  output logic                         prodSign
);

  localparam int sw = fmaPkg::sumWidth;
  // Distance from the product's unit bit to the addend MSB slot
  localparam int topOffset = sw - 2 - (fmaPkg::prodLsb + 14);
  localparam int maxShift  = 80;       // Whole addend gone past this

  logic signed [fmaPkg::expWidth+1:0] prodExp, topExp, cExp, refExpS, shift;
  logic [23:0]     cSig;
  logic [sw-1:0]   cWin;
  logic [2*sw-1:0] shifted;
  logic [6:0]      shiftAmt;

  assign prodSign = a.sign ^ b.sign;
  assign effSub   = prodSign ^ c.sign;

  // Biased product exponent, may leave 0..255 before the final pack
  assign prodExp = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp})
                 - (fmaPkg::expWidth + 2)'(fmaPkg::bias);
  assign topExp  = prodExp + (fmaPkg::expWidth + 2)'(topOffset);
  assign cExp    = $signed({2'b00, c.exp});

  // Window follows the larger of the product and the addend
  assign refExpS = (topExp > cExp) ? topExp : cExp;
  assign refExp  = refExpS;
  assign shift   = refExpS - cExp;    // Never negative
  assign shiftAmt = (shift > maxShift) ? 7'(maxShift) : shift[6:0];

  // Subnormal addend is zero
  assign cSig = (c.exp == '0) ? 24'd0 : {1'b1, c.frac};
  assign cWin = {1'b0, cSig, {(sw - 25){1'b0}}};   // MSB in slot sw-2

  //////////////////////////////////////////////////////////////////////
  // Right shift, spill collects into sticky
  //////////////////////////////////////////////////////////////////////

  assign shifted   = {cWin, {sw{1'b0}}} >> shiftAmt;
  assign addendSig = shifted[2*sw-1:sw];
  assign sticky    = |shifted[sw-1:0];

endmodule

// File: boothMultiplier.sv
`timescale 1ns/10ps

module boothMultiplier (
  input  logic [7:0]  mx,
  input  logic [7:0]  my,
  output logic [15:0] product
);

  localparam int groups = 5;
  localparam int rowW   = 18;

  // Constant part of the sign-extension trick, with the negate bits
  localparam logic [rowW-1:0] signCorr = 18'h1_5600;

  logic [9:0]      mxExt;
  logic [9:0]      myExt;
  logic [2:0]      digit [groups];
  logic [groups-1:0] single, double, neg;
  logic [8:0]      epp [groups];
  logic [rowW-1:0] rows [groups+1];
  logic [rowW-1:0] accSum, accCarry, finalSum;

  assign mxExt = {1'b0, mx, 1'b0};    // Zero below LSB and above MSB
  assign myExt = {1'b0, my, 1'b0};    // Same padding for the shifted multiple

  //////////////////////////////////////////////////////////////////////
  // Radix-4 recoding and multiple select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int j = 0; j < groups; j++) begin
      if (j == groups - 1) begin
        digit[j] = {2'b00, mxExt[2*j]};
      end else begin
        digit[j] = mxExt[2*j +: 3];
      end
      single[j] = digit[j][0] ^ digit[j][1];
      double[j] = (digit[j] == 3'b100) || (digit[j] == 3'b011);
      neg[j]    = digit[j][2];
      for (int k = 0; k < 9; k++) begin
        epp[j][k] = neg[j] ^ ((single[j] & myExt[k+1]) | (double[j] & myExt[k]));
      end
    end
  end

  // Rows with inverted sign bit, then one row of negate bits and correction
  always_comb begin
    for (int j = 0; j < groups; j++) begin
      rows[j] = rowW'({~neg[j], epp[j]}) << (2 * j);
    end
    rows[groups] = signCorr;
    for (int j = 0; j < groups; j++) begin
      rows[groups][2*j] = neg[j];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Carry-save reduction
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    logic [rowW-1:0] maj;
    accSum   = rows[0];
    accCarry = rows[1];
    for (int r = 2; r <= groups; r++) begin
      maj      = (accSum & accCarry) | (accSum & rows[r]) | (accCarry & rows[r]);
      accSum   = accSum ^ accCarry ^ rows[r];
      accCarry = maj << 1;
    end
  end

  assign finalSum = accSum + accCarry;   // Wraps modulo 2^18
  assign product  = finalSum[15:0];

endmodule

// File: specialCases.sv
`timescale 1ns/10ps

module specialCases (
  input  fmaPkg::bf16T    a,
  input  fmaPkg::bf16T    b,
  input  fmaPkg::fp32T    c,
  output fmaPkg::specialT special
);

  logic aNaN, bNaN, cNaN;
  logic aInf, bInf, cInf;
  logic aZero, bZero, cZero;
  logic prodSign, prodInf, prodZero, setNaN;

  // Exponent all ones splits into NaN and infinity by the fraction
  assign aNaN = (a.exp == '1) && (a.frac != '0);
  assign bNaN = (b.exp == '1) && (b.frac != '0);
  assign cNaN = (c.exp == '1) && (c.frac != '0);
  assign aInf = (a.exp == '1) && (a.frac == '0);
  assign bInf = (b.exp == '1) && (b.frac == '0);
  assign cInf = (c.exp == '1) && (c.frac == '0);

  // Subnormals count as zero
  assign aZero = (a.exp == '0);
  assign bZero = (b.exp == '0);
  assign cZero = (c.exp == '0);

  assign prodSign = a.sign ^ b.sign;
  assign prodInf  = aInf | bInf;
  assign prodZero = aZero | bZero;

  assign setNaN = aNaN | bNaN | cNaN
                | (aInf & bZero) | (bInf & aZero)      // Inf times zero
                | (prodInf & cInf & (prodSign != c.sign));

  always_comb begin
    special.isSpecial = 1'b1;
    special.word      = c;
    if (setNaN) begin
      special.word = fmaPkg::quietNaN;
    end else if (prodInf) begin
      special.word = {prodSign, {fmaPkg::expWidth{1'b1}}, {fmaPkg::spFracWidth{1'b0}}};
    end else if (cInf) begin
      special.word = c;                                // Already the signed infinity
    end else if (prodZero) begin
      if (cZero) begin
        // -0 only when both terms are negative zero
        special.word = {prodSign & c.sign, 31'b0};
      end else begin
        special.word = c;
      end
    end else begin
      special.isSpecial = 1'b0;
    end
  end

endmodule

// File: fmaPkg.sv
package fmaPkg;

  //////////////////////////////////////////////////////////////////////
  // Format constants
  //////////////////////////////////////////////////////////////////////

  parameter int expWidth    = 8;
  parameter int bias        = 127;
  parameter int bfFracWidth = 7;    // bfloat16 fraction
  parameter int spFracWidth = 23;   // fp32 fraction

  // Internal sum window
  // Product LSB sits at prodLsb, addend MSB slot at sumWidth-2,
  // top bit left free for the carry of an addition
  parameter int sumWidth = 56;
  parameter int prodLsb  = 12;

  parameter logic [31:0] quietNaN = 32'h7FC0_0000;

  //////////////////////////////////////////////////////////////////////
  // Field and stage types
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   sign;
    logic [expWidth-1:0]    exp;
    logic [bfFracWidth-1:0] frac;
  } bf16T;

  typedef struct packed {
    logic                   sign;
    logic [expWidth-1:0]    exp;
    logic [spFracWidth-1:0] frac;
  } fp32T;

  typedef enum logic {
    rndZero        = 1'b0,
    rndNearestEven = 1'b1
  } roundModeE;

  typedef struct packed {
    logic isSpecial;
    fp32T word;
  } specialT;

  typedef struct packed {
    logic                  prodSign;
    logic                  effSub;
    logic [15:0]           product;
    logic [sumWidth-1:0]   addendSig;
    logic                  sticky;
    logic [expWidth+1:0]   refExp;   // Weight of window bit sumWidth-2
    roundModeE             rnd;
    specialT               special;
  } alignedT;

  typedef struct packed {
    logic                sign;
    logic [sumWidth-1:0] mag;
    logic                sticky;
    logic [expWidth+1:0] exp;
  } sumT;

endpackage
